// ==== logic/cdc_pkg.sv ====
//----------------------------------------------------------
// structure constants of the clk1 to clk2 crossing
// SLOT_COUNT must be a power of two so the slot index wraps
// STRB_GAP of 2 is the fastest rate the strobe crossing allows
//----------------------------------------------------------

package cdc_pkg;

  // buffer depth, equal to the number of credits in the producer
  localparam int SLOT_COUNT = 4;

  // slot index width
  localparam int SLOT_IDX_W = $clog2(SLOT_COUNT);

  // min source clock cycles between two strobe events
  localparam int STRB_GAP = 2;

  // counter widths that must hold 0 .. SLOT_COUNT and 0 .. STRB_GAP
  localparam int CNT_W = $clog2(SLOT_COUNT + 1);
  localparam int GAP_W = $clog2(STRB_GAP + 1);

  // full credit value and gap counter reload
  localparam logic [CNT_W-1:0] CRED_FULL = CNT_W'(SLOT_COUNT);
  localparam logic [GAP_W-1:0] GAP_LOAD = GAP_W'(STRB_GAP - 1);

endpackage

// ==== logic/msg_pkg.sv ====
//----------------------------------------------------------
// message payload and buffer write bundle
// slot_wr_t depends on the index width in cdc_pkg
//----------------------------------------------------------

package msg_pkg;

  // payload field widths
  localparam int TAG_W = 4;
  localparam int DATA_W = 16;

  // one message, 20 bits
  typedef struct packed {
    // short identifier
    logic [TAG_W-1:0] tag;
    // payload word
    logic [DATA_W-1:0] data;
  } msg_t;

  // one buffer write from the producer
  typedef struct packed {
    // write enable, single clk1 cycle
    logic en;
    // target slot
    logic [cdc_pkg::SLOT_IDX_W-1:0] idx;
    // message stored into the slot
    msg_t msg;
  } slot_wr_t;

endpackage

// ==== logic/cdc_strobe.sv ====
//----------------------------------------------------------
// single-pulse strobe crossing from clk1 to clk2
// input events must be STRB_GAP or more clk1 cycles apart
// a long strb1 counts as one event
// every high cycle of strb2 is a separate event
// false path needed from all *_FP_ATTR registers
//----------------------------------------------------------
`timescale 1ns/1ps

module cdc_strobe (
  input  logic arst,
  input  logic clk1,
  input  logic strb1,
  input  logic clk2,
  output logic strb2
);

  //----------------------------------------------------------
  // clk1 side
  //----------------------------------------------------------

  // previous strb1 for edge detect
  logic strb1_b;
  always_ff @(posedge clk1 or posedge arst) begin
    if (arst) begin
      strb1_b <= 1'b0;
    end else begin
      strb1_b <= strb1;
    end
  end

  // one event per rising edge of strb1
  logic strb1_ed;
  assign strb1_ed = strb1 && !strb1_b && !arst;

  // 2-bit gray counter, one step per event
  // it is never reset, clk2 follows whatever value it holds
  logic [1:0] gc_FP_ATTR = 2'b00;
  always @(posedge clk1) begin
    if (strb1_ed) begin
      // 00 -> 01 -> 11 -> 10 -> 00
      gc_FP_ATTR <= {gc_FP_ATTR[0], ~gc_FP_ATTR[1]};
    end
  end

  //----------------------------------------------------------
  // clk2 side
  //----------------------------------------------------------

  // two samples of the counter, only one bit changes per step
  // so a late sample just shows the old value for one more cycle
  logic [1:0][1:0] gc_b;
  always_ff @(posedge clk2 or posedge arst) begin
    if (arst) begin
      gc_b <= {2{gc_FP_ATTR}};
    end else begin
      gc_b <= {gc_b[0], gc_FP_ATTR};
    end
  end

  // counter moved between the two samples
  assign strb2 = (gc_b[1] != gc_b[0]);

  // events spaced by at least STRB_GAP clk1 cycles
  a_strb1_gap: assert property (@(posedge clk1) disable iff (arst)
    strb1_ed |=> !strb1_ed [*cdc_pkg::STRB_GAP-1])
    else $error("cdc_strobe: strb1 events closer than STRB_GAP");

endmodule

// ==== logic/msg_producer.sv ====
//----------------------------------------------------------
// clk1 side of the mailbox
// holds one credit per slot and never writes a slot
// that has not been released by a credit strobe
// fill strobes leave one clk1 cycle after the slot write
//----------------------------------------------------------
`timescale 1ns/1ps

module msg_producer (
  input  logic              clk1,
  input  logic              arst,
  input  logic              in_valid,
  output logic              in_ready,
  input  msg_pkg::msg_t     in_msg,
  output msg_pkg::slot_wr_t slot_wr,
  output logic              fill_strb1,
  input  logic              cred_strb1
);

  //----------------------------------------------------------
  // state
  //----------------------------------------------------------

  // free slots, 0 .. SLOT_COUNT
  logic [cdc_pkg::CNT_W-1:0] credits;
  // next slot to write
  logic [cdc_pkg::SLOT_IDX_W-1:0] wr_idx;
  // clk1 cycles left before the next accept
  logic [cdc_pkg::GAP_W-1:0] gap_cnt;

  logic accept;

  // ready needs a free slot and an expired gap
  assign in_ready = (credits != '0) && (gap_cnt == '0);
  assign accept = in_valid && in_ready;

  // slot write goes out in the accept cycle
  assign slot_wr.en = accept;
  assign slot_wr.idx = wr_idx;
  assign slot_wr.msg = in_msg;

  //----------------------------------------------------------
  // credits, write index and spacing
  //----------------------------------------------------------

  always_ff @(posedge clk1 or posedge arst) begin
    if (arst) begin
      credits <= cdc_pkg::CRED_FULL;
    end else begin
      // take and return may land in the same cycle
      unique case ({accept, cred_strb1})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk1 or posedge arst) begin
    if (arst) begin
      wr_idx <= '0;
    end else if (accept) begin
      // wraps at SLOT_COUNT
      wr_idx <= wr_idx + 1'b1;
    end
  end

  // gap keeps fill strobes STRB_GAP cycles apart
  always_ff @(posedge clk1 or posedge arst) begin
    if (arst) begin
      gap_cnt <= '0;
    end else if (accept) begin
      gap_cnt <= cdc_pkg::GAP_LOAD;
    end else if (gap_cnt != '0) begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

  // fill strobe one cycle after the write, slot is settled by then
  always_ff @(posedge clk1 or posedge arst) begin
    if (arst) begin
      fill_strb1 <= 1'b0;
    end else begin
      fill_strb1 <= accept;
    end
  end

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // a credit returned while full means the consumer popped twice
  a_cred_max: assert property (@(posedge clk1) disable iff (arst)
    credits <= cdc_pkg::CRED_FULL)
    else $error("msg_producer: credits above SLOT_COUNT");

endmodule

// ==== logic/slot_buffer.sv ====
//----------------------------------------------------------
// message slots written on clk1, read from clk2
// the read mux is a false path, a slot does not change
// until its credit comes back to the producer
// false path needed from all *_FP_ATTR registers
//----------------------------------------------------------
`timescale 1ns/1ps

module slot_buffer (
  input  logic                           clk1,
  input  msg_pkg::slot_wr_t              slot_wr,
  input  logic [cdc_pkg::SLOT_IDX_W-1:0] rd_idx,
  output msg_pkg::msg_t                  rd_msg
);

  //----------------------------------------------------------
  // storage
  //----------------------------------------------------------

  // one register per slot
  // contents are only read after a fill strobe, so no reset
  msg_pkg::msg_t slot_FP_ATTR [cdc_pkg::SLOT_COUNT];

  // write port in clk1
  always_ff @(posedge clk1) begin
    if (slot_wr.en) begin
      slot_FP_ATTR[slot_wr.idx] <= slot_wr.msg;
    end
  end

  //----------------------------------------------------------
  // read port
  //----------------------------------------------------------

  // plain mux, rd_idx comes from the clk2 domain
  // the consumer registers the result before use
  assign rd_msg = slot_FP_ATTR[rd_idx];

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // an X index would smear the write over several slots
  a_wr_idx_known: assert property (@(posedge clk1)
    slot_wr.en |-> !$isunknown(slot_wr.idx))
    else $error("slot_buffer: write to unknown index");

endmodule

// ==== logic/msg_consumer.sv ====
//----------------------------------------------------------
// clk2 side of the mailbox
// each high cycle of fill_strb2 marks one filled slot
// slots are presented in write order with valid/ready
// out_valid drops for one cycle after each pop so
// credit strobes stay STRB_GAP clk2 cycles apart
//----------------------------------------------------------
`timescale 1ns/1ps

module msg_consumer (
  input  logic                           clk2,
  input  logic                           arst,
  input  logic                           fill_strb2,
  output logic [cdc_pkg::SLOT_IDX_W-1:0] rd_idx,
  input  msg_pkg::msg_t                  rd_msg,
  output logic                           out_valid,
  input  logic                           out_ready,
  output msg_pkg::msg_t                  out_msg,
  output logic                           cred_strb2
);

  //----------------------------------------------------------
  // state
  //----------------------------------------------------------

  // filled slots not yet popped, the presented one included
  logic [cdc_pkg::CNT_W-1:0] pend_cnt;

  logic pop;
  logic load;

  assign pop = out_valid && out_ready;

  // present the next slot when idle and something is waiting
  assign load = !out_valid && (pend_cnt != '0);

  //----------------------------------------------------------
  // pending count and read index
  //----------------------------------------------------------

  always_ff @(posedge clk2 or posedge arst) begin
    if (arst) begin
      pend_cnt <= '0;
    end else begin
      // fill and pop may land in the same cycle
      unique case ({fill_strb2, pop})
        2'b10: pend_cnt <= pend_cnt + 1'b1;
        2'b01: pend_cnt <= pend_cnt - 1'b1;
        default: pend_cnt <= pend_cnt;
      endcase
    end
  end

  always_ff @(posedge clk2 or posedge arst) begin
    if (arst) begin
      rd_idx <= '0;
    end else if (pop) begin
      // wraps at SLOT_COUNT, follows the producer order
      rd_idx <= rd_idx + 1'b1;
    end
  end

  //----------------------------------------------------------
  // output stage
  //----------------------------------------------------------

  // valid rises one cycle after the count turns nonzero
  // a pop clears it, load cannot fire in that same cycle
  always_ff @(posedge clk2 or posedge arst) begin
    if (arst) begin
      out_valid <= 1'b0;
    end else if (pop) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end
  end

  // payload copy, held while out_ready is low
  always_ff @(posedge clk2) begin
    if (load) begin
      out_msg <= rd_msg;
    end
  end

  // credit back to clk1, one cycle after the pop
  always_ff @(posedge clk2 or posedge arst) begin
    if (arst) begin
      cred_strb2 <= 1'b0;
    end else begin
      cred_strb2 <= pop;
    end
  end

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // more fills than slots means a strobe was doubled in the crossing
  a_pend_max: assert property (@(posedge clk2) disable iff (arst)
    pend_cnt <= cdc_pkg::CRED_FULL)
    else $error("msg_consumer: pending count above SLOT_COUNT");

endmodule

// ==== logic/cdc_mailbox_top.sv ====
//----------------------------------------------------------
// mailbox from clk1 to clk2
// only the fill and credit strobes cross the clocks
// clk2 must sample faster than the strobe spacing
//----------------------------------------------------------
`timescale 1ns/1ps

module cdc_mailbox_top (
  input  logic          clk1,
  input  logic          clk2,
  input  logic          arst,
  input  logic          in_valid,
  output logic          in_ready,
  input  msg_pkg::msg_t in_msg,
  output logic          out_valid,
  input  logic          out_ready,
  output msg_pkg::msg_t out_msg
);

  //----------------------------------------------------------
  // internal nets
  //----------------------------------------------------------

  // clk1 write into the slots
  msg_pkg::slot_wr_t slot_wr;

  // clk2 read of the slots
  logic [cdc_pkg::SLOT_IDX_W-1:0] rd_idx;
  msg_pkg::msg_t rd_msg;

  // fill strobe in both domains
  logic fill_strb1;
  logic fill_strb2;

  // credit strobe in both domains
  logic cred_strb2;
  logic cred_strb1;

  //----------------------------------------------------------
  // clk1 side
  //----------------------------------------------------------

  msg_producer msg_producer_i (
    .clk1       (clk1),
    .arst       (arst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_msg     (in_msg),
    .slot_wr    (slot_wr),
    .fill_strb1 (fill_strb1),
    .cred_strb1 (cred_strb1)
  );

  slot_buffer slot_buffer_i (
    .clk1    (clk1),
    .slot_wr (slot_wr),
    .rd_idx  (rd_idx),
    .rd_msg  (rd_msg)
  );

  //----------------------------------------------------------
  // strobe crossings
  //----------------------------------------------------------

  // slot filled, clk1 to clk2
  cdc_strobe fill_cdc (
    .arst  (arst),
    .clk1  (clk1),
    .strb1 (fill_strb1),
    .clk2  (clk2),
    .strb2 (fill_strb2)
  );

  // slot released, clk2 back to clk1
  cdc_strobe cred_cdc (
    .arst  (arst),
    .clk1  (clk2),
    .strb1 (cred_strb2),
    .clk2  (clk1),
    .strb2 (cred_strb1)
  );

  //----------------------------------------------------------
  // clk2 side
  //----------------------------------------------------------

  msg_consumer msg_consumer_i (
    .clk2       (clk2),
    .arst       (arst),
    .fill_strb2 (fill_strb2),
    .rd_idx     (rd_idx),
    .rd_msg     (rd_msg),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_msg    (out_msg),
    .cred_strb2 (cred_strb2)
  );

endmodule

// ==== testbench/tb_cdc_mailbox.sv ====
//----------------------------------------------------------
// self-checking testbench for the clk1 to clk2 mailbox
// clk1 period 20 ns, clk2 period 26 ns, unrelated phases
// inputs change on the falling edge of their own clock
// the run stops at the first error
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_cdc_mailbox;

  // soak length and run limit, 15 clk1 cycles per message at most
  localparam int SOAK_MSGS = 200;
  localparam int MAX_CYCLES = (SOAK_MSGS + 2 * cdc_pkg::SLOT_COUNT) * 15 + 880;
  localparam int MSG_W = $bits(msg_pkg::msg_t);

  // out_ready modes
  localparam int READY_LOW = 0;
  localparam int READY_HIGH = 1;
  localparam int READY_RAND = 2;

  logic clk1 = 1'b0;
  logic clk2 = 1'b0;
  logic arst;
  logic in_valid;
  logic in_ready;
  msg_pkg::msg_t in_msg;
  logic out_valid;
  logic out_ready;
  msg_pkg::msg_t out_msg;

  // stimulus control, written by the main sequence
  integer seed = 32'hcf389e92;
  int send_left = 0;
  logic valid_rand = 1'b0;
  int ready_mode = READY_LOW;

  // scoreboard
  msg_pkg::msg_t sent_q [$];
  msg_pkg::msg_t exp_msg = '0;
  logic exp_have = 1'b0;
  int acc_cnt = 0;
  int pop_cnt = 0;
  logic pop_seen = 1'b0;
  int cycle_cnt = 0;

  logic [31:0] rnd1;
  logic [31:0] rnd2;

  always #10 clk1 = ~clk1;
  always #13 clk2 = ~clk2;

  cdc_mailbox_top cdc_mailbox_top_i (
    .clk1      (clk1),
    .clk2      (clk2),
    .arst      (arst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_msg    (in_msg),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_msg   (out_msg)
  );

  // print the reason and the verdict, then stop
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  //----------------------------------------------------------
  // drivers and scoreboard bookkeeping
  //----------------------------------------------------------

  // write side, in_ready is settled 1 ns after the falling edge
  // and holds until the next rising edge, so the accept is known early
  always @(negedge clk1) begin
    rnd1 = $random(seed);
    in_valid = (send_left > 0) && (!valid_rand || rnd1[0]);
    in_msg = rnd1[MSG_W:1];
    #1;
    if (in_valid && in_ready) begin
      sent_q.push_back(in_msg);
      acc_cnt++;
      send_left--;
      exp_msg = sent_q[0];
      exp_have = 1'b1;
    end
  end

  // read side, retire the message popped on the last rising edge
  always @(negedge clk2) begin
    if (pop_seen) begin
      void'(sent_q.pop_front());
      pop_cnt++;
    end
    rnd2 = $random(seed);
    case (ready_mode)
      READY_LOW: out_ready = 1'b0;
      READY_HIGH: out_ready = 1'b1;
      default: out_ready = rnd2[0];
    endcase
    #1;
    pop_seen = out_valid && out_ready;
    exp_have = (sent_q.size() != 0);
    if (exp_have) begin
      exp_msg = sent_q[0];
    end
  end

  // run limit
  always @(posedge clk1) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("timeout after %0d clk1 cycles, traffic did not finish",
                          cycle_cnt));
    end
  end

  //----------------------------------------------------------
  // checks
  //----------------------------------------------------------

  // first clk1 edge after reset, full credits and nothing presented
  a_rst_ready: assert property (@(posedge clk1) $fell(arst) |-> in_ready)
    else abort_run($sformatf("CHECK FAILED in_ready expected %h got %h",
                             1'b1, $sampled(in_ready)));

  a_rst_valid: assert property (@(posedge clk1) $fell(arst) |-> !out_valid)
    else abort_run($sformatf("CHECK FAILED out_valid expected %h got %h",
                             1'b0, $sampled(out_valid)));

  // popped payload must be the oldest accepted one
  a_pop_known: assert property (@(posedge clk2) disable iff (arst)
    (out_valid && out_ready) |-> exp_have)
    else abort_run("a message was popped that was never accepted");

  a_pop_order: assert property (@(posedge clk2) disable iff (arst)
    (out_valid && out_ready) |-> (out_msg == exp_msg))
    else abort_run($sformatf("CHECK FAILED out_msg expected %h got %h",
                             $sampled(exp_msg), $sampled(out_msg)));

  // no more than SLOT_COUNT unpopped, count includes this accept
  a_no_overfill: assert property (@(posedge clk1) disable iff (arst)
    (in_valid && in_ready) |-> (acc_cnt - pop_cnt <= cdc_pkg::SLOT_COUNT))
    else abort_run($sformatf("CHECK FAILED in_ready expected %h got %h",
                             1'b0, $sampled(in_ready)));

  // stalled output holds
  a_hold_valid: assert property (@(posedge clk2) disable iff (arst)
    (out_valid && !out_ready) |=> out_valid)
    else abort_run($sformatf("CHECK FAILED out_valid expected %h got %h",
                             1'b1, $sampled(out_valid)));

  a_hold_msg: assert property (@(posedge clk2) disable iff (arst)
    (out_valid && !out_ready) |=> $stable(out_msg))
    else abort_run($sformatf("CHECK FAILED out_msg expected %h got %h",
                             $past(out_msg), $sampled(out_msg)));

  // spacing after an accept and after a pop
  a_gap_in: assert property (@(posedge clk1) disable iff (arst)
    (in_valid && in_ready) |=> !in_ready)
    else abort_run($sformatf("CHECK FAILED in_ready expected %h got %h",
                             1'b0, $sampled(in_ready)));

  a_gap_out: assert property (@(posedge clk2) disable iff (arst)
    (out_valid && out_ready) |=> !out_valid)
    else abort_run($sformatf("CHECK FAILED out_valid expected %h got %h",
                             1'b0, $sampled(out_valid)));

  //----------------------------------------------------------
  // main sequence
  //----------------------------------------------------------

  initial begin
    arst = 1'b1;
    in_valid = 1'b0;
    in_msg = '0;
    out_ready = 1'b0;
    repeat (3) @(posedge clk1);
    @(negedge clk1);
    arst = 1'b0;
    @(posedge clk1);

    // output stalled, offer twice the slot count
    ready_mode = READY_LOW;
    send_left = 2 * cdc_pkg::SLOT_COUNT;
    while (acc_cnt < cdc_pkg::SLOT_COUNT) @(posedge clk1);
    // in_valid stays high here, in_ready must not return
    repeat (40) @(posedge clk1);
    assert (acc_cnt == cdc_pkg::SLOT_COUNT)
      else abort_run($sformatf("CHECK FAILED acc_cnt expected %h got %h",
                               cdc_pkg::SLOT_COUNT, acc_cnt));

    // drain, the credits let the second half through
    ready_mode = READY_HIGH;
    while (pop_cnt < 2 * cdc_pkg::SLOT_COUNT) @(posedge clk1);

    // soak with random valid and ready
    valid_rand = 1'b1;
    ready_mode = READY_RAND;
    send_left = SOAK_MSGS;
    while (pop_cnt < 2 * cdc_pkg::SLOT_COUNT + SOAK_MSGS) @(posedge clk1);
    repeat (20) @(posedge clk1);

    // nothing lost, nothing extra
    if (sent_q.size() == 0 && acc_cnt == pop_cnt) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      abort_run($sformatf("CHECK FAILED pop_cnt expected %h got %h",
                          acc_cnt, pop_cnt));
    end
  end

endmodule

// ==== all.f ====
logic/cdc_pkg.sv
logic/msg_pkg.sv
logic/cdc_strobe.sv
logic/msg_producer.sv
logic/slot_buffer.sv
logic/msg_consumer.sv
logic/cdc_mailbox_top.sv
testbench/tb_cdc_mailbox.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the mailbox testbench with Verilator
# the verdict comes from the simulation log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cdc_mailbox -Mdir obj_dir -f all.f > build.log 2>&1 \
  && { ./obj_dir/Vtb_cdc_mailbox > sim.log 2>&1 || true; } \
  && grep -q "^TESTBENCH PASSED$" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
